// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
+incdir+testbench
source/exec_pkg.sv
source/exec_alu.sv
source/exec_branch_unit.sv
source/exec_muldiv_fsm.sv
source/exec_step_counter.sv
source/exec_muldiv_datapath.sv
source/exec_stage.sv
testbench/exec_stage_tb.sv

// File: source/exec_alu.sv
`default_nettype none

module exec_alu #(
    parameter int XLEN = 32
) (
    input  wire exec_pkg::exec_op_e i_op,
    input  wire logic [XLEN-1:0]    i_op1,
    input  wire logic [XLEN-1:0]    i_op2,
    output logic [XLEN-1:0]         o_result
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    assign shamt       = i_op2[SHAMT_W-1:0]; // Upper bits ignored.
    assign lt_signed   = $signed(i_op1) < $signed(i_op2);
    assign lt_unsigned = i_op1 < i_op2;

    always_comb begin
        case (i_op)
            exec_pkg::OP_ADD: begin
                o_result = i_op1 + i_op2;
            end
            exec_pkg::OP_SUB: begin
                o_result = i_op1 - i_op2;
            end
            exec_pkg::OP_SLL: begin
                o_result = i_op1 << shamt;
            end
            exec_pkg::OP_SRL: begin
                o_result = i_op1 >> shamt;
            end
            exec_pkg::OP_SRA: begin
                o_result = XLEN'($signed(i_op1) >>> shamt); // Sign fill.
            end
            exec_pkg::OP_SLT: begin
                o_result = XLEN'(lt_signed);
            end
            exec_pkg::OP_SLTU: begin
                o_result = XLEN'(lt_unsigned);
            end
            exec_pkg::OP_XOR: begin
                o_result = i_op1 ^ i_op2;
            end
            exec_pkg::OP_OR: begin
                o_result = i_op1 | i_op2;
            end
            exec_pkg::OP_AND: begin
                o_result = i_op1 & i_op2;
            end
            // Multiply/divide results come from the datapath.
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/exec_branch_unit.sv
`default_nettype none

module exec_branch_unit #(
    parameter int XLEN = 32
) (
    input  wire exec_pkg::exec_br_e i_br,
    input  wire logic [XLEN-1:0]    i_pc,
    input  wire logic [XLEN-1:0]    i_imm,
    input  wire logic [XLEN-1:0]    i_op1,
    input  wire logic [XLEN-1:0]    i_op2,
    output logic                    o_taken,
    output logic [XLEN-1:0]         o_target,
    output logic [XLEN-1:0]         o_link
);

    logic            eq;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [XLEN-1:0] pc_rel;
    logic [XLEN-1:0] reg_rel;

    assign eq          = i_op1 == i_op2;
    assign lt_signed   = $signed(i_op1) < $signed(i_op2);
    assign lt_unsigned = i_op1 < i_op2;

    assign pc_rel  = i_pc + i_imm;
    assign reg_rel = (i_op1 + i_imm) & ~XLEN'(1); // JALR clears bit 0.

    always_comb begin
        case (i_br)
            exec_pkg::BR_EQ:   o_taken = eq;
            exec_pkg::BR_NE:   o_taken = !eq;
            exec_pkg::BR_LT:   o_taken = lt_signed;
            exec_pkg::BR_GE:   o_taken = !lt_signed;
            exec_pkg::BR_LTU:  o_taken = lt_unsigned;
            exec_pkg::BR_GEU:  o_taken = !lt_unsigned;
            exec_pkg::BR_JAL,
            exec_pkg::BR_JALR: o_taken = 1'b1;
            default:           o_taken = 1'b0;
        endcase
    end

    assign o_target = (i_br == exec_pkg::BR_JALR) ? reg_rel : pc_rel;
    assign o_link   = i_pc + XLEN'(4); // Return address.

endmodule

`default_nettype wire

// File: source/exec_muldiv_datapath.sv
`default_nettype none

module exec_muldiv_datapath #(
    parameter int XLEN = 32
) (
    input  wire logic               clk,
    input  wire logic               i_arst_n,
    input  wire logic               i_load,
    input  wire logic               i_step,
    input  wire logic               i_fix,
    input  wire exec_pkg::exec_op_e i_op,
    input  wire logic [XLEN-1:0]    i_op1,
    input  wire logic [XLEN-1:0]    i_op2,
    output logic [XLEN-1:0]         o_result
);

    exec_pkg::exec_op_e op_q;
    logic               neg_q;   // Result sign.
    logic [XLEN-1:0]    b_q;     // Multiplicand or divisor magnitude.
    logic [2*XLEN-1:0]  acc_q;   // {high, low} working register.

    logic              a_signed;
    logic              b_signed;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic              neg_d;
    logic              is_div;
    logic [XLEN:0]     part;
    logic [XLEN:0]     diff;
    logic [XLEN:0]     sum;
    logic [2*XLEN-1:0] acc_step;
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   quot;
    logic [XLEN-1:0]   rem;
    logic [XLEN-1:0]   fix_value;

    // Operand signedness per operation.
    assign a_signed = i_op inside {exec_pkg::OP_MULH, exec_pkg::OP_MULHSU,
                                   exec_pkg::OP_DIV, exec_pkg::OP_REM};
    assign b_signed = i_op inside {exec_pkg::OP_MULH, exec_pkg::OP_DIV, exec_pkg::OP_REM};
    assign a_neg    = a_signed && i_op1[XLEN-1];
    assign b_neg    = b_signed && i_op2[XLEN-1];
    assign a_mag    = a_neg ? -i_op1 : i_op1;
    assign b_mag    = b_neg ? -i_op2 : i_op2;

    // Division by zero keeps an all-ones quotient; remainder takes the dividend sign.
    always_comb begin
        case (i_op)
            exec_pkg::OP_DIV,
            exec_pkg::OP_DIVU: neg_d = (a_neg ^ b_neg) && (i_op2 != '0);
            exec_pkg::OP_REM,
            exec_pkg::OP_REMU: neg_d = a_neg;
            default:           neg_d = a_neg ^ b_neg;
        endcase
    end

    assign is_div = op_q inside {exec_pkg::OP_DIV, exec_pkg::OP_DIVU,
                                 exec_pkg::OP_REM, exec_pkg::OP_REMU};

    always_comb begin
        part = acc_q[2*XLEN-1:XLEN-1]; // Remainder shifted left by one.
        diff = part - {1'b0, b_q};
        sum  = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, b_q} : '0);
        if (is_div) begin
            if (!diff[XLEN]) begin
                acc_step = {diff[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
            end else begin
                acc_step = {part[XLEN-1:0], acc_q[XLEN-2:0], 1'b0}; // Restore.
            end
        end else begin
            acc_step = {sum, acc_q[XLEN-1:1]}; // Add then shift right.
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            op_q  <= exec_pkg::OP_MUL;
            neg_q <= 1'b0;
        end else if (i_load) begin
            op_q  <= i_op;
            neg_q <= neg_d;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            b_q   <= b_mag;
            acc_q <= {{XLEN{1'b0}}, a_mag};
        end else if (i_step) begin
            acc_q <= acc_step;
        end
    end

    // Minimum by minus one needs no special case here.
    assign prod = neg_q ? -acc_q : acc_q;
    assign quot = acc_q[XLEN-1:0];
    assign rem  = acc_q[2*XLEN-1:XLEN];

    always_comb begin
        case (op_q)
            exec_pkg::OP_MUL:    fix_value = prod[XLEN-1:0];
            exec_pkg::OP_MULH,
            exec_pkg::OP_MULHSU,
            exec_pkg::OP_MULHU:  fix_value = prod[2*XLEN-1:XLEN];
            exec_pkg::OP_DIV,
            exec_pkg::OP_DIVU:   fix_value = neg_q ? -quot : quot;
            exec_pkg::OP_REM,
            exec_pkg::OP_REMU:   fix_value = neg_q ? -rem : rem;
            default:             fix_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_fix) begin
            o_result <= fix_value;
        end
    end

    // Only multiply/divide operations may reach the load strobe.
    a_load_op: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_load |-> exec_pkg::is_muldiv(i_op)
    ) else $error("Datapath loaded with a non multiply/divide operation.");

endmodule

`default_nettype wire

// File: source/exec_muldiv_fsm.sv
`default_nettype none

module exec_muldiv_fsm (
    input  wire logic clk,
    input  wire logic i_arst_n,
    input  wire logic i_start,
    input  wire logic i_flush,
    input  wire logic i_last,
    output logic      o_load,
    output logic      o_step,
    output logic      o_fix,
    output logic      o_done,
    output logic      o_busy
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (i_start) state_d = RUN;
            RUN:  if (i_last) state_d = FIX; // Last step taken this cycle.
            FIX:  state_d = IDLE;
            default: state_d = IDLE;
        endcase
        if (i_flush) begin
            state_d = IDLE;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= IDLE;
            o_done  <= 1'b0;
        end else begin
            state_q <= state_d;
            o_done  <= (state_q == FIX) && !i_flush; // Pulse after FIX.
        end
    end

    assign o_load = (state_q == IDLE) && i_start && !i_flush;
    assign o_step = state_q == RUN;
    assign o_fix  = state_q == FIX;
    assign o_busy = state_q != IDLE;

    // Issue logic must hold off new operations until IDLE.
    a_start_in_idle: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_start |-> state_q == IDLE
    ) else $error("Multiply/divide started while the unit was busy.");

    a_step_fix_excl: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        !(o_step && o_fix)
    ) else $error("Step and fix strobes overlap.");

endmodule

`default_nettype wire

// File: source/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_SLL    = 5'd2,
        OP_SRL    = 5'd3,
        OP_SRA    = 5'd4,
        OP_SLT    = 5'd5,
        OP_SLTU   = 5'd6,
        OP_XOR    = 5'd7,
        OP_OR     = 5'd8,
        OP_AND    = 5'd9,
        // Multiply/divide unit.
        OP_MUL    = 5'd16,
        OP_MULH   = 5'd17,
        OP_MULHSU = 5'd18,
        OP_MULHU  = 5'd19,
        OP_DIV    = 5'd20,
        OP_DIVU   = 5'd21,
        OP_REM    = 5'd22,
        OP_REMU   = 5'd23
    } exec_op_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7, // Always taken.
        BR_JALR = 4'd8
    } exec_br_e;

    // True for operations handled by the multi-cycle unit.
    function automatic logic is_muldiv(input exec_op_e op);
        logic result;
        result = op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
                            OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        return result;
    endfunction

endpackage

`default_nettype wire

// File: source/exec_stage.sv
`default_nettype none

module exec_stage #(
    parameter int XLEN = 32
) (
    input  wire logic               clk,
    input  wire logic               i_arst_n,
    input  wire logic               i_issue,
    input  wire exec_pkg::exec_op_e i_op,
    input  wire exec_pkg::exec_br_e i_br,
    input  wire logic [XLEN-1:0]    i_pc,
    input  wire logic [XLEN-1:0]    i_imm,
    input  wire logic [XLEN-1:0]    i_op1,
    input  wire logic [XLEN-1:0]    i_op2,
    input  wire logic               i_flush,
    output logic                    o_result_valid,
    output logic [XLEN-1:0]         o_result,
    output logic                    o_branch_taken,
    output logic [XLEN-1:0]         o_branch_target,
    output logic                    o_busy
);

    localparam int STEP_W = $clog2(XLEN);

    logic [XLEN-1:0] alu_result;
    logic            br_taken;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] br_link;
    logic            md_start;
    logic            md_load;
    logic            md_step;
    logic            md_fix;
    logic            md_done;
    logic            md_last;
    logic [XLEN-1:0] md_result;
    logic            alu_fire;
    logic            is_jump;
    logic            alu_valid_q;
    logic            taken_q;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] target_q;

    exec_alu #(.XLEN(XLEN)) exec_alu_i (
        .i_op(i_op), .i_op1(i_op1), .i_op2(i_op2), .o_result(alu_result)
    );

    exec_branch_unit #(.XLEN(XLEN)) exec_branch_unit_i (
        .i_br(i_br), .i_pc(i_pc), .i_imm(i_imm), .i_op1(i_op1), .i_op2(i_op2),
        .o_taken(br_taken), .o_target(br_target), .o_link(br_link)
    );

    assign md_start = i_issue && exec_pkg::is_muldiv(i_op);

    exec_muldiv_fsm exec_muldiv_fsm_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_start(md_start), .i_flush(i_flush),
        .i_last(md_last), .o_load(md_load), .o_step(md_step), .o_fix(md_fix),
        .o_done(md_done), .o_busy(o_busy)
    );

    exec_step_counter #(.XLEN(XLEN), .STEP_W(STEP_W)) exec_step_counter_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_start(md_load), .i_enable(md_step),
        .o_last(md_last)
    );

    exec_muldiv_datapath #(.XLEN(XLEN)) exec_muldiv_datapath_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_load(md_load), .i_step(md_step),
        .i_fix(md_fix), .i_op(i_op), .i_op1(i_op1), .i_op2(i_op2), .o_result(md_result)
    );

    assign alu_fire = i_issue && !o_busy && !exec_pkg::is_muldiv(i_op);
    assign is_jump  = i_br inside {exec_pkg::BR_JAL, exec_pkg::BR_JALR};

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            alu_valid_q <= 1'b0;
            taken_q     <= 1'b0;
        end else begin
            alu_valid_q <= alu_fire;
            taken_q     <= alu_fire && br_taken; // Low for multiply/divide.
        end
    end

    always_ff @(posedge clk) begin
        if (alu_fire) begin
            result_q <= is_jump ? br_link : alu_result;
            target_q <= br_target;
        end
    end

    // Both paths are registered, and never complete in the same cycle.
    assign o_result_valid  = alu_valid_q || md_done;
    assign o_result        = md_done ? md_result : result_q;
    assign o_branch_taken  = taken_q;
    assign o_branch_target = target_q;

    a_no_issue_busy: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_issue |-> !o_busy
    ) else $error("Operation issued while the stage was busy.");

endmodule

`default_nettype wire

// File: source/exec_step_counter.sv
`default_nettype none

module exec_step_counter #(
    parameter int XLEN   = 32,
    parameter int STEP_W = $clog2(XLEN)
) (
    input  wire logic clk,
    input  wire logic i_arst_n,
    input  wire logic i_start,
    input  wire logic i_enable,
    output logic      o_last
);

    logic [STEP_W-1:0] count_q;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count_q <= '0;
        end else if (i_start) begin
            count_q <= STEP_W'(XLEN - 1); // One load per operation.
        end else if (i_enable && !o_last) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign o_last = count_q == '0;

    // Once the final step is taken the sequencer stops stepping until restarted.
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_enable && o_last) |=> (!i_enable || i_start)
    ) else $error("Step counter enabled past zero.");

endmodule

`default_nettype wire

// File: testbench/exec_stage_tb_vectors.svh
`ifndef EXEC_STAGE_TB_VECTORS_SVH
`define EXEC_STAGE_TB_VECTORS_SVH

    // Columns: name, op, op1, op2, result.
    // Branch rows: name, op, br / pc, imm, op1, op2 / result, taken, target.
    task automatic load_fixed_vectors();
        add_op_vector("add", exec_pkg::OP_ADD, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
        add_op_vector("sub", exec_pkg::OP_SUB, 32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
        add_op_vector("sll", exec_pkg::OP_SLL, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
        add_op_vector("srl", exec_pkg::OP_SRL, 32'h8000_0000, 32'h0000_0004, 32'h0800_0000);
        add_op_vector("sra", exec_pkg::OP_SRA, 32'h8000_0000, 32'h0000_0004, 32'hf800_0000);
        add_op_vector("slt", exec_pkg::OP_SLT, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        add_op_vector("sltu", exec_pkg::OP_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
        add_op_vector("xor", exec_pkg::OP_XOR, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
        add_op_vector("or", exec_pkg::OP_OR, 32'hf0f0_f0f0, 32'h0f00_0000, 32'hfff0_f0f0);
        add_op_vector("and", exec_pkg::OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
        add_vector("beq taken", exec_pkg::OP_SUB, exec_pkg::BR_EQ,
                   32'h0000_1000, 32'h0000_0020, 32'h0000_0055, 32'h0000_0055,
                   32'h0000_0000, 1'b1, 32'h0000_1020);
        add_vector("bne not taken", exec_pkg::OP_SUB, exec_pkg::BR_NE,
                   32'h0000_1000, 32'h0000_0020, 32'h0000_0055, 32'h0000_0055,
                   32'h0000_0000, 1'b0, 32'h0000_1020);
        add_vector("blt taken", exec_pkg::OP_SUB, exec_pkg::BR_LT,
                   32'h0000_2000, 32'hffff_fff0, 32'hffff_fffe, 32'h0000_0003,
                   32'hffff_fffb, 1'b1, 32'h0000_1ff0);
        add_vector("bge not taken", exec_pkg::OP_SUB, exec_pkg::BR_GE,
                   32'h0000_2000, 32'hffff_fff0, 32'hffff_fffe, 32'h0000_0003,
                   32'hffff_fffb, 1'b0, 32'h0000_1ff0);
        add_vector("bltu not taken", exec_pkg::OP_SUB, exec_pkg::BR_LTU,
                   32'h0000_2000, 32'hffff_fff0, 32'hffff_fffe, 32'h0000_0003,
                   32'hffff_fffb, 1'b0, 32'h0000_1ff0);
        add_vector("bgeu taken", exec_pkg::OP_SUB, exec_pkg::BR_GEU,
                   32'h0000_2000, 32'hffff_fff0, 32'hffff_fffe, 32'h0000_0003,
                   32'hffff_fffb, 1'b1, 32'h0000_1ff0);
        add_vector("jal", exec_pkg::OP_ADD, exec_pkg::BR_JAL,
                   32'h0000_3000, 32'h0000_0100, 32'h0000_0000, 32'h0000_0000,
                   32'h0000_3004, 1'b1, 32'h0000_3100);
        add_vector("jalr", exec_pkg::OP_ADD, exec_pkg::BR_JALR,
                   32'h0000_3000, 32'h0000_0007, 32'h0000_4000, 32'h0000_0000,
                   32'h0000_3004, 1'b1, 32'h0000_4006);
        add_op_vector("mul", exec_pkg::OP_MUL, 32'hffff_fffd, 32'h0000_0007, 32'hffff_ffeb);
        add_op_vector("mulh", exec_pkg::OP_MULH, 32'hffff_fffd, 32'h0000_0007, 32'hffff_ffff);
        add_op_vector("mulhsu", exec_pkg::OP_MULHSU, 32'hffff_fffd, 32'hffff_ffff, 32'hffff_fffd);
        add_op_vector("mulhu", exec_pkg::OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_op_vector("div", exec_pkg::OP_DIV, 32'hffff_ffec, 32'h0000_0006, 32'hffff_fffd);
        add_op_vector("rem", exec_pkg::OP_REM, 32'hffff_ffec, 32'h0000_0006, 32'hffff_fffe);
        add_op_vector("divu", exec_pkg::OP_DIVU, 32'hffff_ffec, 32'h0000_0006, 32'h2aaa_aaa7);
        add_op_vector("remu", exec_pkg::OP_REMU, 32'hffff_ffec, 32'h0000_0006, 32'h0000_0002);
        add_op_vector("div by zero", exec_pkg::OP_DIV, 32'h1234_5678, 32'h0, 32'hffff_ffff);
        add_op_vector("rem by zero", exec_pkg::OP_REM, 32'h1234_5678, 32'h0, 32'h1234_5678);
        add_op_vector("div overflow", exec_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff,
                      32'h8000_0000);
        add_op_vector("rem overflow", exec_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff,
                      32'h0000_0000);
    endtask

`endif

// File: testbench/exec_stage_tb.sv
`default_nettype none

module exec_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN         = 32;
    localparam int SHW          = $clog2(XLEN);
    localparam int RANDOM_COUNT = 24;

    typedef struct packed {
        exec_pkg::exec_op_e op;
        exec_pkg::exec_br_e br;
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    imm;
        logic [XLEN-1:0]    op1;
        logic [XLEN-1:0]    op2;
        logic [XLEN-1:0]    result;
        logic               taken;
        logic [XLEN-1:0]    target;
    } vec_t;

    logic               clk;
    logic               i_arst_n;
    logic               i_issue;
    exec_pkg::exec_op_e i_op;
    exec_pkg::exec_br_e i_br;
    logic [XLEN-1:0]    i_pc;
    logic [XLEN-1:0]    i_imm;
    logic [XLEN-1:0]    i_op1;
    logic [XLEN-1:0]    i_op2;
    logic               i_flush;
    logic               o_result_valid;
    logic [XLEN-1:0]    o_result;
    logic               o_branch_taken;
    logic [XLEN-1:0]    o_branch_target;
    logic               o_busy;

    vec_t   vecs[$];
    string  names[$];
    integer seed;
    logic   table_ready;

    exec_stage #(.XLEN(XLEN)) exec_stage_i (
        .clk(clk), .i_arst_n(i_arst_n), .i_issue(i_issue), .i_op(i_op), .i_br(i_br),
        .i_pc(i_pc), .i_imm(i_imm), .i_op1(i_op1), .i_op2(i_op2), .i_flush(i_flush),
        .o_result_valid(o_result_valid), .o_result(o_result),
        .o_branch_taken(o_branch_taken), .o_branch_target(o_branch_target),
        .o_busy(o_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual));
        end
    endtask

    // Multiply/divide codes sit at 16 and above.
    function automatic logic multi_cycle(input exec_pkg::exec_op_e op);
        return op >= exec_pkg::OP_MUL;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(input exec_pkg::exec_op_e op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] sa;
        logic [2*XLEN-1:0] sb;
        logic [2*XLEN-1:0] ua;
        logic [2*XLEN-1:0] ub;
        logic [SHW-1:0]    sh;
        logic [XLEN-1:0]   min_val;
        logic              ovf;
        sa      = {{XLEN{a[XLEN-1]}}, a};
        sb      = {{XLEN{b[XLEN-1]}}, b};
        ua      = {{XLEN{1'b0}}, a};
        ub      = {{XLEN{1'b0}}, b};
        sh      = b[SHW-1:0];
        min_val = {1'b1, {(XLEN-1){1'b0}}};
        ovf     = (a == min_val) && (b == '1); // Signed overflow case.
        case (op)
            exec_pkg::OP_ADD:    return a + b;
            exec_pkg::OP_SUB:    return a - b;
            exec_pkg::OP_SLL:    return a << sh;
            exec_pkg::OP_SRL:    return a >> sh;
            exec_pkg::OP_SRA:    return XLEN'($signed(a) >>> sh);
            exec_pkg::OP_SLT:    return XLEN'($signed(a) < $signed(b));
            exec_pkg::OP_SLTU:   return XLEN'(a < b);
            exec_pkg::OP_XOR:    return a ^ b;
            exec_pkg::OP_OR:     return a | b;
            exec_pkg::OP_AND:    return a & b;
            exec_pkg::OP_MUL:    return XLEN'(sa * sb);
            exec_pkg::OP_MULH:   return XLEN'((sa * sb) >> XLEN);
            exec_pkg::OP_MULHSU: return XLEN'((sa * ub) >> XLEN);
            exec_pkg::OP_MULHU:  return XLEN'((ua * ub) >> XLEN);
            exec_pkg::OP_DIV:    return (b == '0) ? '1 : ovf ? min_val : XLEN'($signed(a) / $signed(b));
            exec_pkg::OP_REM:    return (b == '0) ? a : ovf ? '0 : XLEN'($signed(a) % $signed(b));
            exec_pkg::OP_DIVU:   return (b == '0) ? '1 : a / b;
            exec_pkg::OP_REMU:   return (b == '0) ? a : a % b;
            default:             return '0;
        endcase
    endfunction

    task automatic add_vector(input string name, input exec_pkg::exec_op_e op,
                              input exec_pkg::exec_br_e br, input logic [XLEN-1:0] pc,
                              input logic [XLEN-1:0] imm, input logic [XLEN-1:0] op1,
                              input logic [XLEN-1:0] op2, input logic [XLEN-1:0] result,
                              input logic taken, input logic [XLEN-1:0] target);
        vec_t v;
        v.op     = op;
        v.br     = br;
        v.pc     = pc;
        v.imm    = imm;
        v.op1    = op1;
        v.op2    = op2;
        v.result = result;
        v.taken  = taken;
        v.target = target;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    task automatic add_op_vector(input string name, input exec_pkg::exec_op_e op,
                                 input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                 input logic [XLEN-1:0] result);
        add_vector(name, op, exec_pkg::BR_NONE, '0, '0, a, b, result, 1'b0, '0);
    endtask

    `include "exec_stage_tb_vectors.svh"

    task automatic add_random_vectors();
        integer             pick;
        int                 k;
        exec_pkg::exec_op_e op;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            pick = $random(seed);
            k    = (pick & 32'h7fff_ffff) % 18;
            op   = (k < 10) ? exec_pkg::exec_op_e'(5'(k)) : exec_pkg::exec_op_e'(5'(k + 6));
            a    = XLEN'($random(seed));
            b    = XLEN'($random(seed));
            if (pick[9:8] == 2'b00) begin
                b = b >> 24; // Small divisors, sometimes zero.
            end
            add_op_vector($sformatf("random %0d", n), op, a, b, expected_result(op, a, b));
        end
    endtask

    // Called on a falling edge.
    task automatic run_vector(input int idx);
        vec_t  v;
        string name;
        int    edges;
        v       = vecs[idx];
        name    = names[idx];
        i_issue = 1'b1;
        i_op    = v.op;
        i_br    = v.br;
        i_pc    = v.pc;
        i_imm   = v.imm;
        i_op1   = v.op1;
        i_op2   = v.op2;
        @(posedge clk);
        edges = 1; // Issuing edge.
        @(negedge clk);
        i_issue = 1'b0;
        while (!o_result_valid) begin
            if (edges >= XLEN + 2) begin
                fail_run($sformatf("No result strobe for %s within %0d cycles.", name, edges));
            end
            check_value({name, " busy"}, XLEN'(1), XLEN'(o_busy));
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        check_value({name, " latency"}, multi_cycle(v.op) ? XLEN + 2 : 1, XLEN'(edges));
        check_value({name, " result"}, v.result, o_result);
        check_value({name, " taken"}, XLEN'(v.taken), XLEN'(o_branch_taken));
        if (v.br != exec_pkg::BR_NONE) begin
            check_value({name, " target"}, v.target, o_branch_target);
        end
        check_value({name, " busy after result"}, '0, XLEN'(o_busy));
    endtask

    task automatic flush_during_muldiv();
        i_issue = 1'b1;
        i_op    = exec_pkg::OP_DIVU;
        i_br    = exec_pkg::BR_NONE;
        i_op1   = 32'h0001_0000;
        i_op2   = 32'h0000_0003;
        @(negedge clk);
        i_issue = 1'b0;
        repeat (4) @(negedge clk);
        check_value("flush busy before", XLEN'(1), XLEN'(o_busy));
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        check_value("flush busy", '0, XLEN'(o_busy));
        repeat (XLEN + 4) begin
            check_value("flush result_valid", '0, XLEN'(o_result_valid));
            @(negedge clk);
        end
    endtask

    initial begin
        int   limit;
        wait (table_ready === 1'b1);
        limit = (vecs.size() + 1) * (XLEN + 4) + 32;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("Watchdog expired after %0d clock periods.", limit));
    end

    initial begin
        logic flushed;
        table_ready = 1'b0;
        i_arst_n    = 1'b0;
        i_issue     = 1'b0;
        i_op        = exec_pkg::OP_ADD;
        i_br        = exec_pkg::BR_NONE;
        i_pc        = '0;
        i_imm       = '0;
        i_op1       = '0;
        i_op2       = '0;
        i_flush     = 1'b0;
        flushed     = 1'b0;
        seed        = 9128;
        load_fixed_vectors();
        add_random_vectors();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        repeat (2) begin
            check_value("reset result_valid", '0, XLEN'(o_result_valid));
            check_value("reset busy", '0, XLEN'(o_busy));
            check_value("reset branch_taken", '0, XLEN'(o_branch_taken));
            @(negedge clk);
        end
        foreach (vecs[i]) begin
            if (!flushed && multi_cycle(vecs[i].op)) begin
                flush_during_muldiv(); // Next vector checks recovery.
                flushed = 1'b1;
            end
            run_vector(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
